// File: include/tqv_periph_defines.svh
/*
 * Peripheral fabric sizing
 * Widths, slot counts and region decode bits shared by the fabric and its testbench
 */
`ifndef TQV_PERIPH_DEFINES_SVH
`define TQV_PERIPH_DEFINES_SVH

// Core bus widths
`define TQV_ADDR_W        11
`define TQV_DATA_W        32

// Output and input pin count
`define TQV_PINS          8

// Slot counts per region
`define TQV_USER_SLOTS    8
`define TQV_SIMPLE_SLOTS  4

// User slots from this one upwards live outside the fabric
`define TQV_EXT_FIRST     2
`define TQV_EXT_SLOTS     (`TQV_USER_SLOTS - `TQV_EXT_FIRST)

// Offset widths inside a slot (64 byte user, 16 byte simple)
`define TQV_OFFSET_W      6
`define TQV_SIMPLE_OFF_W  4

// Address bit that picks the simple region
`define TQV_REGION_BIT    10

`define TQV_GPIO_SLOT     1
`define TQV_UART_SLOT     2   // Owns pins 0 and 1 out of reset

`endif

// File: rtl/tqv_bus_pkg.sv
/*
 * Core bus types
 * Access size codes, address regions and slot indices
 */
`default_nettype none

`include "tqv_periph_defines.svh"

package tqv_bus_pkg;

    // Request size as driven by the core, all ones means idle
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10,
        SIZE_NONE = 2'b11
    } access_size_t;

    // Taken straight from the region address bit
    typedef enum logic {
        REGION_USER   = 1'b0,
        REGION_SIMPLE = 1'b1
    } region_t;

    typedef logic [$clog2(`TQV_USER_SLOTS)-1:0]   user_slot_t;
    typedef logic [$clog2(`TQV_SIMPLE_SLOTS)-1:0] simple_slot_t;

endpackage

`default_nettype wire

// File: rtl/tqv_gpio_pkg.sv
/*
 * GPIO block types
 * Register offsets and the per-pin output function select
 */
`default_nettype none

`include "tqv_periph_defines.svh"

package tqv_gpio_pkg;

    // Byte offsets inside the GPIO slot
    typedef enum logic [`TQV_OFFSET_W-1:0] {
        GPIO_OUT       = 6'h00,
        GPIO_IN        = 6'h04,
        GPIO_FUNC_BASE = 6'h20   // Pin p select at base + 4*p
    } gpio_reg_t;

    // Output source for one pin
    // When is_simple is set only slot[1:0] is meaningful
    typedef struct packed {
        logic       is_simple;
        logic [2:0] slot;
    } pin_func_t;

endpackage

`default_nettype wire

// File: rtl/periph_bus_if.sv
/*
 * Internal slot bus
 * One decoded access from the address decoder to a built-in peripheral
 */
`timescale 1ns/1ps
`default_nettype none

`include "tqv_periph_defines.svh"

interface periph_bus_if;

    logic [`TQV_OFFSET_W-1:0] offset;
    logic [`TQV_DATA_W-1:0]   wdata;
    logic                     write;   // High only while this slot is written
    logic                     read;    // High only while this slot is read
    logic [`TQV_DATA_W-1:0]   rdata;

    modport dec  (output offset, wdata, write, read, input rdata);
    modport peri (input offset, wdata, write, read, output rdata);

endinterface

`default_nettype wire

// File: rtl/periph_addr_decode.sv
/*
 * Peripheral address decoder
 * Splits the core address into user and simple slot selects and
 * gates write and read strobes, holding reads off while a result waits
 */
`timescale 1ns/1ps
`default_nettype none

`include "tqv_periph_defines.svh"

module periph_addr_decode (
    input  wire [`TQV_ADDR_W-1:0]        i_addr,
    input  wire [`TQV_DATA_W-1:0]        i_wdata,
    input  wire tqv_bus_pkg::access_size_t i_write_n,
    input  wire tqv_bus_pkg::access_size_t i_read_n,
    input  wire                          i_result_pending,

    periph_bus_if.dec                    gpio_bus,

    output logic [`TQV_USER_SLOTS-1:0]   o_user_sel,
    output logic [`TQV_SIMPLE_SLOTS-1:0] o_simple_sel,
    output logic                         o_sel_simple,
    output tqv_bus_pkg::user_slot_t      o_user_idx,
    output tqv_bus_pkg::simple_slot_t    o_simple_idx,
    output tqv_bus_pkg::access_size_t    o_slot_write_n,
    output tqv_bus_pkg::access_size_t    o_slot_read_n
);

    tqv_bus_pkg::region_t region;
    logic                 write_req;
    logic                 read_req;

    assign region       = tqv_bus_pkg::region_t'(i_addr[`TQV_REGION_BIT]);
    assign o_sel_simple = (region == tqv_bus_pkg::REGION_SIMPLE);

    // Bit 9 is not looked at, so the upper half of the user region aliases
    assign o_user_idx   = i_addr[`TQV_OFFSET_W +: $bits(tqv_bus_pkg::user_slot_t)];
    assign o_simple_idx = i_addr[`TQV_SIMPLE_OFF_W +: $bits(tqv_bus_pkg::simple_slot_t)];

    // Second read must not reach a slot while the held result is out
    assign o_slot_write_n = i_write_n;
    assign o_slot_read_n  = i_result_pending ? tqv_bus_pkg::SIZE_NONE : i_read_n;

    assign write_req = (o_slot_write_n != tqv_bus_pkg::SIZE_NONE);
    assign read_req  = (o_slot_read_n != tqv_bus_pkg::SIZE_NONE);

    // One-hot select within the addressed region
    always_comb begin
        o_user_sel   = '0;
        o_simple_sel = '0;
        if (o_sel_simple) begin
            o_simple_sel[o_simple_idx] = 1'b1;
        end else begin
            o_user_sel[o_user_idx] = 1'b1;
        end
    end

    assign gpio_bus.offset = i_addr[`TQV_OFFSET_W-1:0];
    assign gpio_bus.wdata  = i_wdata;
    assign gpio_bus.write  = o_user_sel[`TQV_GPIO_SLOT] & write_req;
    assign gpio_bus.read   = o_user_sel[`TQV_GPIO_SLOT] & read_req;

endmodule

`default_nettype wire

// File: rtl/gpio_regs.sv
/*
 * GPIO register block
 * Output byte, input pin readback and one output function select per pin
 */
`timescale 1ns/1ps
`default_nettype none

`include "tqv_periph_defines.svh"

module gpio_regs (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire [`TQV_PINS-1:0]     i_pins_in,

    periph_bus_if.peri              bus,

    output logic [`TQV_PINS-1:0]    o_gpio_out,
    output tqv_gpio_pkg::pin_func_t [`TQV_PINS-1:0] o_pin_func
);

    localparam int IDX_W = $clog2(`TQV_PINS);

    // Offset bits that carry the pin number of a function select
    localparam logic [`TQV_OFFSET_W-1:0] FUNC_IDX_MASK = `TQV_OFFSET_W'((`TQV_PINS - 1) << 2);

    logic [`TQV_PINS-1:0]                   gpio_out;
    tqv_gpio_pkg::pin_func_t [`TQV_PINS-1:0] func_sel;
    logic                                   func_hit;
    logic [IDX_W-1:0]                       func_idx;

    assign func_hit = ((bus.offset & ~FUNC_IDX_MASK) == tqv_gpio_pkg::GPIO_FUNC_BASE);
    assign func_idx = bus.offset[2 +: IDX_W];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
            for (int p = 0; p < `TQV_PINS; p++) begin
                func_sel[p].is_simple <= 1'b0;
                // UART pins come up on the UART slot, the rest on GPIO
                func_sel[p].slot <= (p == 0 || p == 1) ? 3'(`TQV_UART_SLOT)
                                                       : 3'(`TQV_GPIO_SLOT);
            end
        end else if (bus.write) begin
            if (bus.offset == tqv_gpio_pkg::GPIO_OUT) begin
                gpio_out <= bus.wdata[`TQV_PINS-1:0];
            end
            if (func_hit) begin
                func_sel[func_idx] <= tqv_gpio_pkg::pin_func_t'(bus.wdata[3:0]);
            end
        end
    end

    // Readback, zero at offsets with no register
    always_comb begin
        bus.rdata = '0;
        if (bus.offset == tqv_gpio_pkg::GPIO_OUT) begin
            bus.rdata[`TQV_PINS-1:0] = gpio_out;
        end else if (bus.offset == tqv_gpio_pkg::GPIO_IN) begin
            bus.rdata[`TQV_PINS-1:0] = i_pins_in;   // Already synchronized outside
        end else if (func_hit) begin
            bus.rdata[3:0] = func_sel[func_idx];
        end
    end

    assign o_gpio_out = gpio_out;
    assign o_pin_func = func_sel;

endmodule

`default_nettype wire

// File: rtl/pin_func_router.sv
/*
 * Output pin router
 * Each output pin takes its bit from the slot its function select names
 */
`timescale 1ns/1ps
`default_nettype none

`include "tqv_periph_defines.svh"

module pin_func_router (
    input  wire tqv_gpio_pkg::pin_func_t [`TQV_PINS-1:0]        i_pin_func,
    input  wire [`TQV_PINS-1:0]                                 i_gpio_out,
    input  wire [`TQV_EXT_SLOTS-1:0][`TQV_PINS-1:0]             i_ext_user_uo,
    input  wire [`TQV_SIMPLE_SLOTS-1:0][`TQV_PINS-1:0]          i_simple_uo,
    output logic [`TQV_PINS-1:0]                                o_uo_out
);

    logic [`TQV_USER_SLOTS-1:0][`TQV_PINS-1:0] user_uo;

    // Full user slot table, slot 0 is reserved and drives nothing
    always_comb begin
        user_uo = '0;
        user_uo[`TQV_GPIO_SLOT] = i_gpio_out;
        for (int k = 0; k < `TQV_EXT_SLOTS; k++) begin
            user_uo[`TQV_EXT_FIRST + k] = i_ext_user_uo[k];
        end
    end

    always_comb begin
        tqv_bus_pkg::user_slot_t   u;
        tqv_bus_pkg::simple_slot_t s;
        u = '0;
        s = '0;
        for (int p = 0; p < `TQV_PINS; p++) begin
            u = i_pin_func[p].slot;
            s = tqv_bus_pkg::simple_slot_t'(i_pin_func[p].slot[1:0]);
            // Pin p always takes bit p of its source
            o_uo_out[p] = i_pin_func[p].is_simple ? i_simple_uo[s][p] : user_uo[u][p];
        end
    end

endmodule

`default_nettype wire

// File: rtl/read_return.sv
/*
 * Read return path
 * Picks data and ready from the selected slot, registers the read result
 * and keeps it until the core signals the read complete
 */
`timescale 1ns/1ps
`default_nettype none

`include "tqv_periph_defines.svh"

module read_return (
    input  wire                                      clk,
    input  wire                                      rst_n,
    input  wire                                      i_sel_simple,
    input  wire tqv_bus_pkg::user_slot_t             i_user_idx,
    input  wire tqv_bus_pkg::simple_slot_t           i_simple_idx,
    input  wire [`TQV_DATA_W-1:0]                    i_gpio_rdata,
    input  wire [`TQV_EXT_SLOTS-1:0][`TQV_DATA_W-1:0] i_ext_user_rdata,
    input  wire [`TQV_EXT_SLOTS-1:0]                 i_ext_user_ready,
    input  wire [`TQV_SIMPLE_SLOTS-1:0][7:0]         i_simple_rdata,
    input  wire tqv_bus_pkg::access_size_t           i_read_n,
    input  wire tqv_bus_pkg::access_size_t           i_write_n,
    input  wire                                      i_read_complete,
    output logic [`TQV_DATA_W-1:0]                   o_data_out,
    output logic                                     o_data_ready,
    output logic                                     o_result_pending
);

    logic [`TQV_USER_SLOTS-1:0][`TQV_DATA_W-1:0] user_rdata;
    logic [`TQV_USER_SLOTS-1:0]                  user_ready;
    logic [`TQV_DATA_W-1:0]                      peri_data;
    logic                                        peri_ready;
    logic                                        read_req;
    logic                                        capture;
    logic                                        hold;
    logic                                        ready_r;
    logic [`TQV_DATA_W-1:0]                      data_r;

    // Internal slots answer at once, external ones when they say so
    always_comb begin
        user_rdata = '0;
        user_ready = '1;
        user_rdata[`TQV_GPIO_SLOT] = i_gpio_rdata;
        for (int k = 0; k < `TQV_EXT_SLOTS; k++) begin
            user_rdata[`TQV_EXT_FIRST + k] = i_ext_user_rdata[k];
            user_ready[`TQV_EXT_FIRST + k] = i_ext_user_ready[k];
        end
    end

    always_comb begin
        peri_data = '0;
        if (i_sel_simple) begin
            peri_data[7:0] = i_simple_rdata[i_simple_idx];   // Byte slots, zero extended
            peri_ready     = 1'b1;
        end else begin
            peri_data  = user_rdata[i_user_idx];
            peri_ready = user_ready[i_user_idx];
        end
    end

    assign read_req = (i_read_n != tqv_bus_pkg::SIZE_NONE);
    assign capture  = !hold && peri_ready && read_req;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (i_read_complete) hold <= 1'b0;
            if (capture) hold <= 1'b1;        // New capture wins over complete
            ready_r <= read_req && peri_ready;   // Lines up with data_r
        end
    end

    always_ff @(posedge clk) begin
        if (capture) data_r <= peri_data;
    end

    assign o_data_out       = data_r;
    assign o_data_ready     = ready_r || (i_write_n != tqv_bus_pkg::SIZE_NONE);
    assign o_result_pending = ready_r;

endmodule

`default_nettype wire

// File: rtl/tqv_periph_fabric.sv
/*
 * Peripheral bus fabric top
 * Address decode, GPIO block, pin routing and read return for the core bus
 */
`timescale 1ns/1ps
`default_nettype none

`include "tqv_periph_defines.svh"

module tqv_periph_fabric (
    input  wire                                      clk,
    input  wire                                      rst_n,
    input  wire [`TQV_PINS-1:0]                      i_ui_in,
    input  wire [`TQV_ADDR_W-1:0]                    i_addr,
    input  wire [`TQV_DATA_W-1:0]                    i_data_in,
    input  wire tqv_bus_pkg::access_size_t           i_data_write_n,
    input  wire tqv_bus_pkg::access_size_t           i_data_read_n,
    input  wire                                      i_data_read_complete,

    // External user slots 2 to 7
    input  wire [`TQV_EXT_SLOTS-1:0][`TQV_DATA_W-1:0] i_user_rdata,
    input  wire [`TQV_EXT_SLOTS-1:0]                 i_user_ready,
    input  wire [`TQV_EXT_SLOTS-1:0][`TQV_PINS-1:0]  i_user_uo,

    // External simple slots
    input  wire [`TQV_SIMPLE_SLOTS-1:0][7:0]         i_simple_rdata,
    input  wire [`TQV_SIMPLE_SLOTS-1:0][`TQV_PINS-1:0] i_simple_uo,

    output logic [`TQV_PINS-1:0]                     o_uo_out,
    output logic [`TQV_DATA_W-1:0]                   o_data_out,
    output logic                                     o_data_ready,
    output logic [`TQV_OFFSET_W-1:0]                 o_periph_offset,
    output logic [`TQV_DATA_W-1:0]                   o_periph_wdata,
    output logic [`TQV_USER_SLOTS-1:0]               o_user_sel,
    output logic [`TQV_SIMPLE_SLOTS-1:0]             o_simple_sel,
    output tqv_bus_pkg::access_size_t                o_slot_write_n,
    output tqv_bus_pkg::access_size_t                o_slot_read_n
);

    logic                                    sel_simple;
    tqv_bus_pkg::user_slot_t                 user_idx;
    tqv_bus_pkg::simple_slot_t               simple_idx;
    logic                                    result_pending;
    logic [`TQV_PINS-1:0]                    gpio_out;
    tqv_gpio_pkg::pin_func_t [`TQV_PINS-1:0] pin_func;

    periph_bus_if gpio_bus ();

    periph_addr_decode u_decode (
        .i_addr           (i_addr),
        .i_wdata          (i_data_in),
        .i_write_n        (i_data_write_n),
        .i_read_n         (i_data_read_n),
        .i_result_pending (result_pending),
        .gpio_bus         (gpio_bus.dec),
        .o_user_sel       (o_user_sel),
        .o_simple_sel     (o_simple_sel),
        .o_sel_simple     (sel_simple),
        .o_user_idx       (user_idx),
        .o_simple_idx     (simple_idx),
        .o_slot_write_n   (o_slot_write_n),
        .o_slot_read_n    (o_slot_read_n)
    );

    // Offset and write data are shared by every slot
    assign o_periph_offset = gpio_bus.offset;
    assign o_periph_wdata  = gpio_bus.wdata;

    gpio_regs u_gpio (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_pins_in  (i_ui_in),
        .bus        (gpio_bus.peri),
        .o_gpio_out (gpio_out),
        .o_pin_func (pin_func)
    );

    pin_func_router u_router (
        .i_pin_func    (pin_func),
        .i_gpio_out    (gpio_out),
        .i_ext_user_uo (i_user_uo),
        .i_simple_uo   (i_simple_uo),
        .o_uo_out      (o_uo_out)
    );

    read_return u_return (
        .clk              (clk),
        .rst_n            (rst_n),
        .i_sel_simple     (sel_simple),
        .i_user_idx       (user_idx),
        .i_simple_idx     (simple_idx),
        .i_gpio_rdata     (gpio_bus.rdata),
        .i_ext_user_rdata (i_user_rdata),
        .i_ext_user_ready (i_user_ready),
        .i_simple_rdata   (i_simple_rdata),
        .i_read_n         (i_data_read_n),
        .i_write_n        (i_data_write_n),
        .i_read_complete  (i_data_read_complete),
        .o_data_out       (o_data_out),
        .o_data_ready     (o_data_ready),
        .o_result_pending (result_pending)
    );

endmodule

`default_nettype wire

// File: tb/fabric_checker.sv
/*
 * Fabric checker
 * Watches the fabric ports, keeps a model of the GPIO registers and pin
 * sources, compares each access against the bus rules and reports it
 */
`timescale 1ns/1ps
`default_nettype none

`include "tqv_periph_defines.svh"

module fabric_checker (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire [`TQV_ADDR_W-1:0]              i_addr,
    input  wire [`TQV_DATA_W-1:0]              i_data_in,
    input  wire tqv_bus_pkg::access_size_t     i_data_write_n,
    input  wire tqv_bus_pkg::access_size_t     i_data_read_n,
    input  wire                                i_data_read_complete,
    input  wire [`TQV_EXT_SLOTS-1:0]           i_user_ready,
    input  wire [`TQV_PINS-1:0]                i_uo_out,
    input  wire [`TQV_DATA_W-1:0]              i_data_out,
    input  wire                                i_data_ready,
    input  wire [`TQV_OFFSET_W-1:0]            i_periph_offset,
    input  wire [`TQV_DATA_W-1:0]              i_periph_wdata,
    input  wire [`TQV_USER_SLOTS-1:0]          i_user_sel,
    input  wire [`TQV_SIMPLE_SLOTS-1:0]        i_simple_sel,
    input  wire tqv_bus_pkg::access_size_t     i_slot_write_n,
    input  wire tqv_bus_pkg::access_size_t     i_slot_read_n,
    input  wire                                i_op_active,
    input  wire [1:0]                          i_op,      // 0 write, 1 read, 2 pin check
    input  wire [`TQV_DATA_W-1:0]              i_expect,
    output int                                 o_tests,
    output int                                 o_errors
);

    logic [`TQV_PINS-1:0] user_uo [`TQV_EXT_SLOTS];
    logic [`TQV_PINS-1:0] simple_uo [`TQV_SIMPLE_SLOTS];
    logic [`TQV_PINS-1:0] gpio_out;
    logic [3:0]           func [`TQV_PINS];
    logic [`TQV_DATA_W-1:0] held;
    logic [`TQV_PINS-1:0] exp_pins;
    logic [`TQV_USER_SLOTS-1:0]   exp_user;
    logic [`TQV_SIMPLE_SLOTS-1:0] exp_simple;
    tqv_bus_pkg::access_size_t    exp_read_n;
    logic                 holding;
    logic                 ready_due;
    logic                 slot_ready;
    logic                 reset_seen;
    logic                 test_fail;
    int                   slot;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        o_errors++;
        test_fail = 1'b1;
    endtask

    task automatic failure(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        o_errors++;
        test_fail = 1'b1;
    endtask

    // Same pin source bytes as the slot models, one LFSR step per bit
    initial begin
        logic [31:0] state;
        state = 32'h224568fd;
        for (int k = 0; k < `TQV_EXT_SLOTS; k++) begin
            for (int b = 0; b < 8; b++) begin
                user_uo[k][b] = state[0];
                state = lfsr_next(state);
            end
        end
        for (int k = 0; k < `TQV_SIMPLE_SLOTS; k++) begin
            for (int b = 0; b < 8; b++) begin
                simple_uo[k][b] = state[0];
                state = lfsr_next(state);
            end
        end
        o_tests = 0;
        o_errors = 0;
    end

    always @(negedge clk) begin
        if (!rst_n) begin
            gpio_out = '0;
            for (int p = 0; p < `TQV_PINS; p++) begin
                func[p] = (p < 2) ? 4'(`TQV_UART_SLOT) : 4'(`TQV_GPIO_SLOT);
            end
            holding = 1'b0;
            ready_due = 1'b0;
            reset_seen = 1'b0;
            test_fail = 1'b0;
        end else begin
            if (!reset_seen && i_data_ready) mismatch("o_data_ready", 1, 0);
            reset_seen = 1'b1;

            // A write is answered in the cycle it is presented
            if (i_data_write_n != tqv_bus_pkg::SIZE_NONE && !i_data_ready) begin
                mismatch("o_data_ready", 0, 1);
            end

            // Slot ready must show up as o_data_ready one cycle later
            if (ready_due && !i_data_ready) failure("o_data_ready did not follow slot ready");
            slot = int'(i_addr[8:6]) - `TQV_EXT_FIRST;
            slot_ready = i_addr[10] || slot < 0 || i_user_ready[slot];
            ready_due = (i_data_read_n != tqv_bus_pkg::SIZE_NONE) && slot_ready && !i_data_ready;

            // Writes pass straight to the slots, reads are held off while a result is out
            if (i_slot_write_n !== i_data_write_n) begin
                mismatch("o_slot_write_n", 32'(i_slot_write_n), 32'(i_data_write_n));
            end
            if (i_data_write_n == tqv_bus_pkg::SIZE_NONE) begin
                exp_read_n = i_data_ready ? tqv_bus_pkg::SIZE_NONE : i_data_read_n;
                if (i_slot_read_n !== exp_read_n) begin
                    mismatch("o_slot_read_n", 32'(i_slot_read_n), 32'(exp_read_n));
                end
            end

            // One-hot selects, bit 9 plays no part in the user region
            if (i_data_write_n != tqv_bus_pkg::SIZE_NONE
                || i_data_read_n != tqv_bus_pkg::SIZE_NONE) begin
                exp_user = i_addr[10] ? '0 : (8'd1 << i_addr[8:6]);
                exp_simple = i_addr[10] ? (4'd1 << i_addr[5:4]) : '0;
                if (i_user_sel !== exp_user) mismatch("o_user_sel", 32'(i_user_sel), 32'(exp_user));
                if (i_simple_sel !== exp_simple) begin
                    mismatch("o_simple_sel", 32'(i_simple_sel), 32'(exp_simple));
                end
                if (i_periph_offset !== i_addr[5:0]) begin
                    mismatch("o_periph_offset", 32'(i_periph_offset), 32'(i_addr[5:0]));
                end
            end
            if (i_data_write_n != tqv_bus_pkg::SIZE_NONE && i_periph_wdata !== i_data_in) begin
                mismatch("o_periph_wdata", i_periph_wdata, i_data_in);
            end

            if (holding) begin
                if (i_data_out !== held) mismatch("o_data_out (held)", i_data_out, held);
                if (i_data_read_complete) holding = 1'b0;
            end

            if (i_op_active && (i_op == 2'd2 || i_data_ready)) begin
                if (i_op == 2'd2) begin
                    for (int p = 0; p < `TQV_PINS; p++) begin
                        if (func[p][3]) exp_pins[p] = simple_uo[func[p][1:0]][p];
                        else if (func[p][2:0] == 3'd0) exp_pins[p] = 1'b0;
                        else if (func[p][2:0] == 3'(`TQV_GPIO_SLOT)) exp_pins[p] = gpio_out[p];
                        else exp_pins[p] = user_uo[func[p][2:0] - `TQV_EXT_FIRST][p];
                    end
                    if (i_uo_out !== exp_pins) mismatch("o_uo_out", 32'(i_uo_out), 32'(exp_pins));
                end else if (i_op == 2'd1) begin
                    if (i_data_out !== i_expect) mismatch("o_data_out", i_data_out, i_expect);
                    held = i_expect;
                    holding = 1'b1;
                end else if (!i_addr[10] && i_addr[8:6] == 3'(`TQV_GPIO_SLOT)) begin
                    if (i_addr[5:0] == 6'h00) gpio_out = i_data_in[7:0];
                    if (i_addr[5] && i_addr[1:0] == 2'b00) func[i_addr[4:2]] = i_data_in[3:0];
                end
                o_tests++;
                $display("Test %0d %s addr %h: %s", o_tests,
                         (i_op == 2'd0) ? "write" : (i_op == 2'd1) ? "read" : "pins",
                         i_addr, test_fail ? "FAIL" : "ok");
                test_fail = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_fabric.sv
/*
 * Fabric testbench
 * Clock, reset, trace driven bus accesses and models of the external slots
 */
`timescale 1ns/1ps
`default_nettype none

`include "tqv_periph_defines.svh"

module tb_fabric;

    localparam int MAX_LINES = 64;
    localparam int COLS      = 7;

    logic                                     clk;
    logic                                     rst_n;
    logic [`TQV_PINS-1:0]                     ui_in;
    logic [`TQV_ADDR_W-1:0]                   addr;
    logic [`TQV_DATA_W-1:0]                   data_in;
    tqv_bus_pkg::access_size_t                write_n;
    tqv_bus_pkg::access_size_t                read_n;
    logic                                     read_complete;
    logic [`TQV_EXT_SLOTS-1:0][`TQV_DATA_W-1:0] user_rdata;
    logic [`TQV_EXT_SLOTS-1:0]                user_ready;
    logic [`TQV_EXT_SLOTS-1:0][`TQV_PINS-1:0] user_uo;
    logic [`TQV_SIMPLE_SLOTS-1:0][7:0]        simple_rdata;
    logic [`TQV_SIMPLE_SLOTS-1:0][`TQV_PINS-1:0] simple_uo;
    logic [`TQV_PINS-1:0]                     uo_out;
    logic [`TQV_DATA_W-1:0]                   data_out;
    logic                                     data_ready;
    logic [`TQV_OFFSET_W-1:0]                 periph_offset;
    logic [`TQV_DATA_W-1:0]                   periph_wdata;
    logic [`TQV_USER_SLOTS-1:0]               user_sel;
    logic [`TQV_SIMPLE_SLOTS-1:0]             simple_sel;
    tqv_bus_pkg::access_size_t                slot_write_n;
    tqv_bus_pkg::access_size_t                slot_read_n;
    logic                                     op_active;
    logic [1:0]                               op;
    logic [`TQV_DATA_W-1:0]                   expect_val;
    logic [31:0]                              trace [0:MAX_LINES*COLS-1];
    int                                       n_lines;
    int                                       cycles;
    int                                       limit;
    int                                       tests;
    int                                       errors;

    tqv_periph_fabric uut (
        .clk (clk), .rst_n (rst_n), .i_ui_in (ui_in), .i_addr (addr),
        .i_data_in (data_in), .i_data_write_n (write_n), .i_data_read_n (read_n),
        .i_data_read_complete (read_complete),
        .i_user_rdata (user_rdata), .i_user_ready (user_ready), .i_user_uo (user_uo),
        .i_simple_rdata (simple_rdata), .i_simple_uo (simple_uo),
        .o_uo_out (uo_out), .o_data_out (data_out), .o_data_ready (data_ready),
        .o_periph_offset (periph_offset), .o_periph_wdata (periph_wdata),
        .o_user_sel (user_sel), .o_simple_sel (simple_sel),
        .o_slot_write_n (slot_write_n), .o_slot_read_n (slot_read_n)
    );

    fabric_checker u_checker (
        .clk (clk), .rst_n (rst_n), .i_addr (addr), .i_data_in (data_in),
        .i_data_write_n (write_n), .i_data_read_n (read_n),
        .i_data_read_complete (read_complete), .i_user_ready (user_ready),
        .i_uo_out (uo_out), .i_data_out (data_out), .i_data_ready (data_ready),
        .i_periph_offset (periph_offset), .i_periph_wdata (periph_wdata),
        .i_user_sel (user_sel), .i_simple_sel (simple_sel),
        .i_slot_write_n (slot_write_n), .i_slot_read_n (slot_read_n),
        .i_op_active (op_active), .i_op (op), .i_expect (expect_val),
        .o_tests (tests), .o_errors (errors)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: the fabric did not answer within %0d cycles", limit);
            $display("Some tests failed");
            $finish;
        end
    end

    // One trace line: present the access, model the slot, wait for the answer
    task automatic run_line(input int i);
        logic [1:0]  opc;
        logic [10:0] a;
        int          delay;
        int          k;
        opc   = trace[i*COLS][1:0];
        a     = trace[i*COLS+1][10:0];
        delay = int'(trace[i*COLS+4]);
        k     = int'(a[8:6]) - `TQV_EXT_FIRST;
        @(posedge clk);
        addr         <= a;
        op           <= opc;
        expect_val   <= trace[i*COLS+6];
        op_active    <= 1'b1;
        user_rdata   <= '0;
        simple_rdata <= '0;
        if (opc == 2'd0) begin
            data_in <= trace[i*COLS+3];
            write_n <= tqv_bus_pkg::access_size_t'(trace[i*COLS+2][1:0]);
        end else if (opc == 2'd1) begin
            read_n <= tqv_bus_pkg::access_size_t'(trace[i*COLS+2][1:0]);
            if (a[10]) simple_rdata[a[5:4]] <= trace[i*COLS+5][7:0];
            else if (k >= 0) user_rdata[k] <= trace[i*COLS+5];
            if (!a[10] && k >= 0 && delay == 0) user_ready[k] <= 1'b1;
        end
        if (opc == 2'd1 && !a[10] && k >= 0 && delay > 0) begin
            repeat (delay) @(posedge clk);
            user_ready[k] <= 1'b1;   // Slow slot answers late
        end
        @(negedge clk);
        while (opc != 2'd2 && !data_ready) @(negedge clk);
        @(posedge clk);
        op_active <= 1'b0;
        if (opc == 2'd1) begin
            // Slot data moves on while the read is still presented
            user_rdata   <= ~user_rdata;
            simple_rdata <= ~simple_rdata;
            @(posedge clk);
        end
        write_n       <= tqv_bus_pkg::SIZE_NONE;
        read_n        <= tqv_bus_pkg::SIZE_NONE;
        user_ready    <= '0;
        read_complete <= (opc == 2'd1);
        @(posedge clk);
        read_complete <= 1'b0;
    endtask

    initial begin
        logic [31:0] state;
        clk = 1'b0;
        rst_n = 1'b0;
        cycles = 0;
        limit = 1000;
        ui_in = 8'hA5;
        addr = '0;
        data_in = '0;
        write_n = tqv_bus_pkg::SIZE_NONE;
        read_n = tqv_bus_pkg::SIZE_NONE;
        read_complete = 1'b0;
        user_rdata = '0;
        user_ready = '0;
        simple_rdata = '0;
        op_active = 1'b0;
        op = 2'd0;
        expect_val = '0;
        state = 32'h224568fd;
        for (int k = 0; k < `TQV_EXT_SLOTS; k++) begin
            for (int b = 0; b < 8; b++) begin
                user_uo[k][b] = state[0];
                state = lfsr_next(state);
            end
        end
        for (int k = 0; k < `TQV_SIMPLE_SLOTS; k++) begin
            for (int b = 0; b < 8; b++) begin
                simple_uo[k][b] = state[0];
                state = lfsr_next(state);
            end
        end
        $readmemh("tb/fabric_trace.txt", trace);
        n_lines = 0;
        while (n_lines < MAX_LINES && trace[n_lines*COLS] != 32'hFF) n_lines++;
        limit = 20 * n_lines + 100;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < n_lines; i++) run_line(i);
        repeat (2) @(posedge clk);
        $display("Tests run %0d of %0d, errors %0d", tests, n_lines, errors);
        if (errors == 0 && tests == n_lines) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/fabric_trace.txt
// op(0 write 1 read 2 pins) addr size(0 byte 2 word) wdata ext_delay slot_rdata expected
// Reset state, GPIO out and input readback
2 000 2 00 0 00000000 00000000
1 040 2 00 0 00000000 00000000
0 040 2 3C 0 00000000 00000000
1 040 2 00 0 00000000 0000003C
1 044 2 00 0 00000000 000000A5
1 240 2 00 0 00000000 0000003C
// External user slots, slow and immediate
1 0C0 2 00 3 DEADBEEF DEADBEEF
1 1C4 2 00 0 12345678 12345678
1 088 2 00 1 0BADF00D 0BADF00D
// Simple slots, reserved slot and empty GPIO offset
1 420 0 00 0 0000009A 0000009A
1 430 0 00 0 000000F1 000000F1
1 000 2 00 0 00000000 00000000
1 050 2 00 0 00000000 00000000
// Function selects and routing
0 060 2 09 0 00000000 00000000
0 064 2 05 0 00000000 00000000
0 068 2 00 0 00000000 00000000
0 06C 2 01 0 00000000 00000000
0 070 2 0C 0 00000000 00000000
0 07C 2 07 0 00000000 00000000
2 000 2 00 0 00000000 00000000
1 060 2 00 0 00000000 00000009
1 07C 2 00 0 00000000 00000007
0 040 2 FF 0 00000000 00000000
2 000 2 00 0 00000000 00000000
FF 0 0 0 0 0 0

// File: flist.f
+incdir+include
rtl/tqv_bus_pkg.sv
rtl/tqv_gpio_pkg.sv
rtl/periph_bus_if.sv
rtl/periph_addr_decode.sv
rtl/gpio_regs.sv
rtl/pin_func_router.sv
rtl/read_return.sv
rtl/tqv_periph_fabric.sv
tb/fabric_checker.sv
tb/tb_fabric.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the fabric testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_fabric -o sim_fabric
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_fabric)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
